//--- Bender.yml
package:
  name: rv32i_pipe

sources:
  - common/isa_pkg.sv
  - common/core_pkg.sv
  - common/dmem_if.sv
  - core/alu.sv
  - core/regfile.sv
  - core/decoder.sv
  - core/core.sv
  - rtl/instmem.sv
  - rtl/datamem.sv
  - rtl/cpu_top.sv
  - target: test
    files:
      - tb/tb_cpu.sv

//--- common/core_pkg.sv
package core_pkg;
	import isa_pkg::*;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	// Write-back source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_LOAD,
		WB_PC4   // Link address of JAL
	} wb_sel_e;

	// Decoded control, travels down the pipe with the instruction
	typedef struct packed {
		alu_op_e    alu_op;
		logic       sel_imm;    // Operand B from immediate
		logic       wr_en;      // Register write in WB
		logic [3:0] dm_write;   // Byte enables for MEM
		wb_sel_e    wb_sel;
		logic       is_branch;
		logic       br_ne;      // BNE, else BEQ
		logic       is_jump;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = ctrl_t'('0);  // Bubble, every enable low

endpackage

//--- common/dmem_if.sv
`timescale 1ns/1ps

// Core side of the data memory, word addressed
interface dmem_if
	import core_pkg::*;
#(
	parameter int DMEM_WORDS = 256
);
	localparam int AW = $clog2(DMEM_WORDS);

	logic [AW-1:0] addr;       // Word index
	word_t         wdata;
	logic [3:0]    dm_write;   // Byte enables, all set on SW
	word_t         rdata;      // Combinational read

	modport core (output addr, output wdata, output dm_write, input rdata);
	modport mem  (input addr, input wdata, input dm_write, output rdata);
endinterface

//--- common/isa_pkg.sv
package isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Instruction fields
	////////////////////////////////////////////////////////////////////////////

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// Major opcodes of the supported subset
	localparam opcode_t OP_REG    = 7'b0110011;  // ADD SUB AND OR XOR
	localparam opcode_t OP_IMM    = 7'b0010011;  // ADDI only
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;

	localparam funct3_t F3_ADD_SUB = 3'h0;
	localparam funct3_t F3_XOR     = 3'h4;
	localparam funct3_t F3_OR      = 3'h6;
	localparam funct3_t F3_AND     = 3'h7;
	localparam funct3_t F3_BEQ     = 3'h0;
	localparam funct3_t F3_BNE     = 3'h1;
	localparam funct3_t F3_LW      = 3'h2;   // Word access only
	localparam funct3_t F3_SW      = 3'h2;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000;  // Selects SUB

	// ALU operation
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASSB    // LUI
	} alu_op_e;

endpackage

//--- core/alu.sv
`timescale 1ns/1ps

module alu
	import isa_pkg::*;
	import core_pkg::*;
(
	input  word_t   op_a,
	input  word_t   op_b,
	input  alu_op_e alu_op,
	output word_t   res,
	output logic    z
);

	always_comb begin
		case (alu_op)
			ALU_ADD:   res = op_a + op_b;   // Also address calc
			ALU_SUB:   res = op_a - op_b;
			ALU_AND:   res = op_a & op_b;
			ALU_OR:    res = op_a | op_b;
			ALU_XOR:   res = op_a ^ op_b;
			ALU_PASSB: res = op_b;          // LUI immediate
			default:   res = '0;
		endcase
	end

	assign z = (res == '0);   // Equal operands on SUB

endmodule

//--- core/core.sv
`timescale 1ns/1ps

module core
	import core_pkg::*;
#(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
)(
	input  logic                          CLK,
	input  logic                          rst,
	output logic [$clog2(IMEM_WORDS)-1:0] inst_addr,   // PC word index
	input  word_t                         inst,
	dmem_if.core                          dmem
);
	localparam int IAW = $clog2(IMEM_WORDS);
	localparam int DAW = $clog2(DMEM_WORDS);

	typedef logic [IAW+1:0] pc_t;   // Byte address over the imem range

	// IF stage
	pc_t      pc;
	pc_t      pc4;
	pc_t      pc_next;
	// ID stage
	word_t    id_inst;
	pc_t      id_pc;
	ctrl_t    id_ctrl;
	word_t    id_imm;
	word_t    id_a, id_b;          // Regfile outputs
	// EXE stage
	ctrl_t    exe_ctrl;
	pc_t      exe_pc;
	word_t    exe_a, exe_b, exe_imm;
	reg_idx_t exe_rd;
	word_t    exe_op_b;
	word_t    exe_res;
	logic     exe_z;
	logic     br_taken;            // Also the flush of IF/ID and ID/EXE
	pc_t      br_target;
	word_t    exe_link;            // PC + 4 for JAL
	// MEM stage
	ctrl_t    mem_ctrl;
	word_t    mem_res, mem_store, mem_link;
	reg_idx_t mem_rd;
	// WB stage
	ctrl_t    wb_ctrl;
	word_t    wb_res, wb_load, wb_link, wb_data;
	reg_idx_t wb_rd;

	////////////////////////////////////////////////////////////////////////////
	// IF
	////////////////////////////////////////////////////////////////////////////

	assign pc4       = pc + pc_t'(4);
	assign pc_next   = br_taken ? br_target : pc4;   // Static not-taken
	assign inst_addr = pc[IAW+1:2];

	always_ff @(posedge CLK) begin
		if (rst) pc <= '0;
		else pc <= pc_next;
	end

	always_ff @(posedge CLK) begin
		if (rst || br_taken) id_inst <= '0;   // Zero opcode decodes as bubble
		else id_inst <= inst;
		id_pc <= pc;
	end

	////////////////////////////////////////////////////////////////////////////
	// ID
	////////////////////////////////////////////////////////////////////////////

	decoder dec0 (.inst(id_inst), .ctrl(id_ctrl), .imm(id_imm));

	regfile rf0 (
		.CLK(CLK), .rst(rst),
		.wr_en(wb_ctrl.wr_en), .wr_addr(wb_rd), .wr_data(wb_data),
		.rs1(id_inst[19:15]), .rs2(id_inst[24:20]),
		.rd1(id_a), .rd2(id_b)
	);

	always_ff @(posedge CLK) begin
		if (rst || br_taken) exe_ctrl <= CTRL_NOP;
		else exe_ctrl <= id_ctrl;
		exe_pc  <= id_pc;
		exe_a   <= id_a;
		exe_b   <= id_b;
		exe_imm <= id_imm;
		exe_rd  <= id_inst[11:7];
	end

	////////////////////////////////////////////////////////////////////////////
	// EXE
	////////////////////////////////////////////////////////////////////////////

	assign exe_op_b = exe_ctrl.sel_imm ? exe_imm : exe_b;

	alu alu0 (.op_a(exe_a), .op_b(exe_op_b), .alu_op(exe_ctrl.alu_op),
		.res(exe_res), .z(exe_z));

	// BEQ takes on zero, BNE on nonzero difference
	assign br_taken  = exe_ctrl.is_jump | (exe_ctrl.is_branch & (exe_z ^ exe_ctrl.br_ne));
	assign br_target = exe_pc + exe_imm[IAW+1:0];
	assign exe_link  = word_t'(exe_pc + pc_t'(4));

	always_ff @(posedge CLK) begin
		if (rst) mem_ctrl <= CTRL_NOP;
		else mem_ctrl <= exe_ctrl;
		mem_res   <= exe_res;
		mem_store <= exe_b;      // rs2 is the SW data
		mem_link  <= exe_link;
		mem_rd    <= exe_rd;
	end

	////////////////////////////////////////////////////////////////////////////
	// MEM
	////////////////////////////////////////////////////////////////////////////

	assign dmem.addr     = mem_res[DAW+1:2];
	assign dmem.wdata    = mem_store;
	assign dmem.dm_write = mem_ctrl.dm_write;

	always_ff @(posedge CLK) begin
		if (rst) wb_ctrl <= CTRL_NOP;
		else wb_ctrl <= mem_ctrl;
		wb_res  <= mem_res;
		wb_load <= dmem.rdata;
		wb_link <= mem_link;
		wb_rd   <= mem_rd;
	end

	////////////////////////////////////////////////////////////////////////////
	// WB
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (wb_ctrl.wb_sel)
			WB_ALU:  wb_data = wb_res;
			WB_LOAD: wb_data = wb_load;
			WB_PC4:  wb_data = wb_link;
			default: wb_data = wb_res;
		endcase
	end

	// A store never also writes a register
	a_store_no_wb: assert property (@(posedge CLK) disable iff (rst)
		!((|mem_ctrl.dm_write) && mem_ctrl.wr_en));

endmodule

//--- core/decoder.sv
`timescale 1ns/1ps

module decoder
	import isa_pkg::*;
	import core_pkg::*;
(
	input  word_t inst,
	output ctrl_t ctrl,
	output word_t imm
);
	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	always_comb begin
		ctrl = CTRL_NOP;   // Unknown opcodes stay a bubble
		imm  = '0;
		case (opcode)
			OP_REG: if (funct7 == F7_BASE || funct7 == F7_ALT) begin
				ctrl.wr_en = 1'b1;
				case (funct3)
					F3_ADD_SUB: ctrl.alu_op = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
					F3_XOR:     ctrl.alu_op = ALU_XOR;
					F3_OR:      ctrl.alu_op = ALU_OR;
					F3_AND:     ctrl.alu_op = ALU_AND;
					default:    ctrl.wr_en  = 1'b0;
				endcase
			end
			OP_IMM: if (funct3 == F3_ADD_SUB) begin   // ADDI
				ctrl.wr_en   = 1'b1;
				ctrl.sel_imm = 1'b1;
				imm = {{20{inst[31]}}, inst[31:20]};            // I
			end
			OP_LUI: begin
				ctrl.wr_en   = 1'b1;
				ctrl.sel_imm = 1'b1;
				ctrl.alu_op  = ALU_PASSB;
				imm = {inst[31:12], 12'h000};                    // U
			end
			OP_LOAD: if (funct3 == F3_LW) begin
				ctrl.wr_en   = 1'b1;
				ctrl.sel_imm = 1'b1;
				ctrl.wb_sel  = WB_LOAD;
				imm = {{20{inst[31]}}, inst[31:20]};            // I
			end
			OP_STORE: if (funct3 == F3_SW) begin
				ctrl.dm_write = 4'hf;   // Whole word
				ctrl.sel_imm  = 1'b1;
				imm = {{20{inst[31]}}, inst[31:25], inst[11:7]}; // S
			end
			OP_BRANCH: if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
				ctrl.is_branch = 1'b1;
				ctrl.br_ne     = (funct3 == F3_BNE);
				ctrl.alu_op    = ALU_SUB;   // Compare via zero flag
				imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};    // B
			end
			OP_JAL: begin
				ctrl.is_jump = 1'b1;
				ctrl.wr_en   = 1'b1;
				ctrl.wb_sel  = WB_PC4;
				imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};  // J
			end
			default: ;
		endcase
	end

endmodule

//--- core/regfile.sv
`timescale 1ns/1ps

module regfile
	import core_pkg::*;
(
	input  logic     CLK,
	input  logic     rst,
	input  logic     wr_en,
	input  reg_idx_t wr_addr,
	input  word_t    wr_data,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	output word_t    rd1,
	output word_t    rd2
);
	word_t regs [32];

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-through, so ID sees the value retiring in WB
	assign rd1 = (rs1 == '0) ? '0 : (wr_en && rs1 == wr_addr) ? wr_data : regs[rs1];
	assign rd2 = (rs2 == '0) ? '0 : (wr_en && rs2 == wr_addr) ? wr_data : regs[rs2];

	a_x0_kept: assert property (@(posedge CLK) disable iff (rst)
		(wr_en && wr_addr == '0) |=> regs[0] == '0);

endmodule

//--- rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
	import core_pkg::*;
#(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
)(
	input  logic                          CLK,
	input  logic                          rst,
	// Program load, used during reset
	input  logic                          prog_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
	input  word_t                         prog_data,
	// Controller port of data memory
	input  logic [3:0]                    con_write,
	input  logic [9:0]                    con_addr,
	input  word_t                         con_in,
	output word_t                         con_out
);
	logic [$clog2(IMEM_WORDS)-1:0] inst_addr;
	word_t                         inst;

	dmem_if #(.DMEM_WORDS(DMEM_WORDS)) dmem_bus ();

	core #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) core0 (
		.CLK(CLK), .rst(rst), .inst_addr(inst_addr), .inst(inst), .dmem(dmem_bus.core)
	);

	instmem #(.IMEM_WORDS(IMEM_WORDS)) imem0 (
		.CLK(CLK), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .addr(inst_addr), .inst(inst)
	);

	datamem #(.DMEM_WORDS(DMEM_WORDS)) dmem0 (
		.CLK(CLK), .dmem(dmem_bus.mem), .con_write(con_write), .con_addr(con_addr),
		.con_in(con_in), .con_out(con_out)
	);

endmodule

//--- rtl/datamem.sv
`timescale 1ns/1ps

module datamem
	import core_pkg::*;
#(
	parameter int DMEM_WORDS = 256
)(
	input  logic       CLK,
	dmem_if.mem        dmem,
	input  logic [3:0] con_write,   // Byte lanes from controller
	input  logic [9:0] con_addr,
	input  word_t      con_in,
	output word_t      con_out
);
	localparam int AW = $clog2(DMEM_WORDS);

	word_t         mem [DMEM_WORDS];
	logic [AW-1:0] con_idx;

	assign con_idx = con_addr[AW-1:0];

	always_ff @(posedge CLK) begin
		for (int b = 0; b < 4; b++) begin
			if (con_write[b]) mem[con_idx][8*b +: 8] <= con_in[8*b +: 8];
			// Core lane assigned last, wins on a collision
			if (dmem.dm_write[b]) mem[dmem.addr][8*b +: 8] <= dmem.wdata[8*b +: 8];
		end
	end

	assign dmem.rdata = mem[dmem.addr];
	assign con_out    = mem[con_idx];

endmodule

//--- rtl/instmem.sv
`timescale 1ns/1ps

module instmem
	import core_pkg::*;
#(
	parameter int IMEM_WORDS = 256
)(
	input  logic                          CLK,
	input  logic                          rst,
	input  logic                          prog_we,
	input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr,
	input  word_t                         prog_data,
	input  logic [$clog2(IMEM_WORDS)-1:0] addr,
	output word_t                         inst
);
	word_t mem [IMEM_WORDS];

	always_ff @(posedge CLK) begin
		if (prog_we) mem[prog_addr] <= prog_data;   // Program load
	end

	assign inst = mem[addr];   // Async fetch

	// Loading only while the core is held
	a_load_in_reset: assert property (@(posedge CLK) prog_we |-> rst);

endmodule

//--- tb.f
common/isa_pkg.sv
common/core_pkg.sv
common/dmem_if.sv
core/alu.sv
core/regfile.sv
core/decoder.sv
core/core.sv
rtl/instmem.sv
rtl/datamem.sv
rtl/cpu_top.sv
tb/tb_cpu.sv

//--- tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
	import isa_pkg::*;
	import core_pkg::*;
();
	localparam int    WORDS = 256;
	localparam word_t NOP   = 32'h0000_0013;   // ADDI x0, x0, 0

	logic                     CLK = 1'b0;
	logic                     rst;
	logic                     prog_we;
	logic [$clog2(WORDS)-1:0] prog_addr;
	word_t                    prog_data;
	logic [3:0]               con_write;
	logic [9:0]               con_addr;
	word_t                    con_in;
	word_t                    con_out;

	word_t  prog [WORDS];       // Program image for imem
	word_t  init_mem [WORDS];   // Data image written before release
	word_t  exp_mem [WORDS];    // Expected image from the ISA model
	int     n;                  // Next free program slot
	integer seed;
	int     t, i, errs, n_pass, n_fail;
	bit     ok;
	string  names [6] = '{"arith", "load_store", "branch", "jump", "x0", "con_port"};

	cpu_top #(.IMEM_WORDS(WORDS), .DMEM_WORDS(WORDS)) dut0 (
		.CLK(CLK), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
		.prog_data(prog_data), .con_write(con_write), .con_addr(con_addr),
		.con_in(con_in), .con_out(con_out)
	);

	always #2 CLK = ~CLK;   // 4 ns period

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t r_type(funct7_t f7, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
			reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic word_t i_type(opcode_t op, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
			logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t s_type(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t b_type(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	function automatic word_t u_type(reg_idx_t rd, logic [19:0] imm);
		return {imm, rd, OP_LUI};
	endfunction

	function automatic word_t j_type(reg_idx_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
	endfunction

	// Word at address w, differs per test
	function automatic word_t fill_word(int tn, int w);
		return {8'hC0, 8'(tn), 8'(w), ~8'(w)};
	endfunction

	task automatic place(word_t w);   // No padding
		prog[n] = w;
		n++;
	endtask

	task automatic emit(word_t w);    // Three NOPs cover any dependency
		place(w);
		repeat (3) place(NOP);
	endtask

	task automatic load_const(reg_idx_t rd, word_t v);
		word_t hi;
		hi = (v + 32'h800) >> 12;   // Rounds for the signed low part
		emit(u_type(rd, hi[19:0]));
		emit(i_type(OP_IMM, F3_ADD_SUB, rd, rd, v[11:0]));
	endtask

	// Branch that must be taken, two poison stores in its shadow
	task automatic taken_branch(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, int pw);
		int bi;
		bi = n;
		place(NOP);
		place(s_type(20, 0, 12'(4 * pw)));
		place(s_type(20, 0, 12'(4 * (pw + 1))));
		prog[bi] = b_type(f3, rs1, rs2, 13'((n - bi) * 4));
	endtask

	task automatic finish_program();
		emit(i_type(OP_IMM, F3_ADD_SUB, 31, 0, 12'd1));
		emit(s_type(31, 0, 12'd1020));   // Marker, word 255
		place(j_type(0, '0));            // Spin
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test programs
	////////////////////////////////////////////////////////////////////////////

	task automatic build_program(int tn);
		word_t ra, rb, rc;
		int    k, bi;
		ra = $random(seed);
		rb = $random(seed);
		rc = $random(seed);
		case (tn)
			0: begin
				load_const(1, ra);
				load_const(2, rb);
				emit(r_type(F7_BASE, F3_ADD_SUB, 3, 1, 2));
				emit(r_type(F7_ALT, F3_ADD_SUB, 4, 1, 2));
				emit(r_type(F7_BASE, F3_AND, 5, 1, 2));
				emit(r_type(F7_BASE, F3_OR, 6, 1, 2));
				emit(r_type(F7_BASE, F3_XOR, 7, 1, 2));
				emit(i_type(OP_IMM, F3_ADD_SUB, 8, 1, rc[11:0]));
				emit(u_type(9, rc[31:12]));
				for (k = 1; k < 10; k++) emit(s_type(k, 0, 12'(4 * (10 + k))));
			end
			1: begin
				for (k = 0; k < 4; k++) init_mem[40 + k] = $random(seed);   // Preloaded
				load_const(10, 32'd160);   // Base of word 40
				for (k = 0; k < 4; k++) emit(i_type(OP_LOAD, F3_LW, 11 + k, 10, 12'(4 * k)));
				for (k = 0; k < 4; k++)
					emit(i_type(OP_IMM, F3_ADD_SUB, 11 + k, 11 + k, 12'($random(seed))));
				for (k = 0; k < 4; k++) emit(s_type(11 + k, 10, 12'(40 + 4 * k)));
			end
			2: begin
				load_const(1, ra);
				load_const(2, ra);
				load_const(3, ra ^ 32'h10);
				load_const(20, 32'hDEAD_BEEF);
				taken_branch(F3_BEQ, 1, 2, 60);
				emit(s_type(1, 0, 12'(4 * 62)));
				place(b_type(F3_BNE, 1, 2, 13'd64));   // Falls through
				emit(s_type(3, 0, 12'(4 * 63)));
				taken_branch(F3_BNE, 1, 3, 64);
				emit(s_type(2, 0, 12'(4 * 66)));
				place(b_type(F3_BEQ, 1, 3, 13'd64));   // Falls through
				emit(s_type(1, 0, 12'(4 * 67)));
			end
			3: begin
				load_const(20, 32'hDEAD_BEEF);
				bi = n;
				place(NOP);
				for (k = 0; k < 3; k++) place(s_type(20, 0, 12'(4 * (70 + k))));
				prog[bi] = j_type(5, 21'((n - bi) * 4));
				emit(s_type(5, 0, 12'(4 * 73)));   // Link value
			end
			4: begin
				load_const(1, ra);
				emit(i_type(OP_IMM, F3_ADD_SUB, 0, 0, 12'h7ff));
				emit(u_type(0, rb[31:12]));
				emit(r_type(F7_BASE, F3_ADD_SUB, 0, 1, 1));
				emit(i_type(OP_LOAD, F3_LW, 0, 0, 12'd0));
				emit(s_type(0, 0, 12'(4 * 80)));
				emit(r_type(F7_BASE, F3_OR, 2, 0, 0));
				emit(s_type(2, 0, 12'(4 * 81)));
			end
			default: begin
				// Program leaves these alone
				for (k = 0; k < 8; k++) init_mem[100 + k] = $random(seed);
			end
		endcase
		finish_program();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// ISA reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic void run_model();
		word_t    x [32];
		word_t    pc, nxt, ins, a, b, res, addr;
		word_t    imm_i, imm_s, imm_b, imm_j;
		reg_idx_t rd;
		logic     wr, halted;
		int       k, steps;
		for (k = 0; k < 32; k++) x[k] = '0;
		pc     = '0;
		halted = 1'b0;
		steps  = 0;
		while (!halted && steps < 4000) begin
			ins   = prog[pc[9:2]];
			rd    = ins[11:7];
			a     = x[ins[19:15]];
			b     = x[ins[24:20]];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
			imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			nxt   = pc + 32'd4;
			res   = '0;
			wr    = 1'b0;
			case (ins[6:0])
				OP_REG: begin
					wr = 1'b1;
					case (ins[14:12])
						3'h0:    res = ins[30] ? a - b : a + b;
						3'h4:    res = a ^ b;
						3'h6:    res = a | b;
						3'h7:    res = a & b;
						default: wr = 1'b0;
					endcase
				end
				OP_IMM: begin
					wr  = 1'b1;
					res = a + imm_i;
				end
				OP_LUI: begin
					wr  = 1'b1;
					res = {ins[31:12], 12'h000};
				end
				OP_LOAD: begin
					addr = a + imm_i;
					wr   = 1'b1;
					res  = exp_mem[addr[9:2]];
				end
				OP_STORE: begin
					addr = a + imm_s;
					exp_mem[addr[9:2]] = b;
				end
				OP_BRANCH: if ((a == b) ^ ins[12]) nxt = pc + imm_b;   // funct3 bit 0 is BNE
				OP_JAL: begin
					wr  = 1'b1;
					res = pc + 32'd4;
					nxt = pc + imm_j;
				end
				default: ;
			endcase
			if (wr && rd != 5'd0) x[rd] = res;
			halted = (nxt == pc);   // Jump to self ends the program
			pc     = nxt;
			steps++;
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Load, run and compare
	////////////////////////////////////////////////////////////////////////////

	// Program and data image go in while the core is held
	task automatic load_and_reset();
		int k;
		@(posedge CLK);
		rst <= 1'b1;
		for (k = 0; k < WORDS; k++) begin
			@(posedge CLK);
			prog_we   <= 1'b1;
			prog_addr <= k[$clog2(WORDS)-1:0];
			prog_data <= prog[k];
			con_write <= 4'hf;
			con_addr  <= 10'(k);
			con_in    <= init_mem[k];
		end
		@(posedge CLK);
		prog_we   <= 1'b0;
		con_write <= 4'h0;
		con_addr  <= 10'd255;   // Poll the marker
		repeat (8) @(posedge CLK);
		rst <= 1'b0;
	endtask

	task automatic wait_marker(output bit done);
		int cyc;
		done = 1'b0;
		for (cyc = 0; cyc < 3000 && !done; cyc++) begin
			@(negedge CLK);
			if (con_out == 32'd1) done = 1'b1;
		end
	endtask

	task automatic compare_image(inout int err_cnt);
		int w;
		for (w = 0; w < WORDS; w++) begin
			@(posedge CLK);
			con_addr <= 10'(w);
			@(negedge CLK);   // con_out settled
			if (con_out !== exp_mem[w]) begin
				$display("MISMATCH at time %0t: con_out (word %0d) got %h, expected %h",
					$time, w, con_out, exp_mem[w]);
				err_cnt++;
			end
		end
	endtask

	initial begin
		seed      = 71803;
		rst       = 1'b1;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		con_write = 4'h0;
		con_addr  = '0;
		con_in    = '0;
		n_pass    = 0;
		n_fail    = 0;
		for (t = 0; t < 6; t++) begin
			n = 0;
			for (i = 0; i < WORDS; i++) begin
				prog[i]     = NOP;
				init_mem[i] = fill_word(t, i);
			end
			build_program(t);
			for (i = 0; i < WORDS; i++) exp_mem[i] = init_mem[i];
			run_model();
			load_and_reset();
			wait_marker(ok);
			errs = 0;
			if (!ok) begin
				$display("test %0d (%s): end-of-program marker never appeared in data memory",
					t, names[t]);
				errs = 1;
			end else begin
				compare_image(errs);
			end
			if (errs == 0) begin
				$display("test %0d (%s): pass", t, names[t]);
				n_pass++;
			end else begin
				$display("test %0d (%s): fail, %0d errors", t, names[t], errs);
				n_fail++;
			end
		end
		$display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule
